// ==== vlog.f ====
+incdir+test
source/cp0Pkg.sv
source/cp0Links.sv
source/excCollector.sv
source/irqSampler.sv
source/cp0Regs.sv
source/cp0Top.sv
test/cp0Tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = cp0Tb
RTL_TOP   = cp0Top
FILELIST  = vlog.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Result: PASSED" $(LOG) && ! grep -q "Result: FAILED" $(LOG)

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== test/cp0Model.svh ====
`ifndef CP0MODEL_SVH
`define CP0MODEL_SVH

// Architectural state as the take rules describe it
logic [31:0] mStatus;   // Bit 1 is EXL, bit 0 is IE, bits 15:10 mask the lines
logic [31:0] mCause;
logic [31:0] mEpc;
logic [5:0]  mHwReg;    // Lines as sampled one edge earlier
logic        mTaken;
logic        mAck;
logic [31:0] mDatR;

function automatic logic [31:0] modelRead(input logic [4:0] adr);
    case (adr)
        regStatus: return mStatus;
        regCause:  return mCause;
        regEpc:    return mEpc;
        regPrid:   return pridValue;
        default:   return 32'd0;
    endcase
endfunction

task automatic modelReset();
    mStatus = statusInit;
    mCause  = 32'd0;
    mEpc    = 32'd0;
    mHwReg  = 6'd0;
    mTaken  = 1'b0;
    mAck    = 1'b0;
    mDatR   = 32'd0;
endtask

// One clock edge with the inputs that are driven now
task automatic modelStep();
    logic        memAny;
    logic        excValid;
    logic [4:0]  code;
    logic [31:0] victim;
    logic        irqReq;
    logic        take;
    logic        accept;
    memAny   = memAdEL | memAdES | memOv;
    excValid = memAny | decRi | decSyscall | decBreak;
    // Older memory stage first
    if (memAdEL)
        code = excAdEL;
    else if (memAdES)
        code = excAdES;
    else if (memOv)
        code = excOv;
    else if (decRi)
        code = excRi;
    else if (decSyscall)
        code = excSyscall;
    else if (decBreak)
        code = excBreak;
    else
        code = excInt;
    if (memAny)
        victim = memBranchDelay ? pcMemNext - 32'd8 : pcMemNext - 32'd4;
    else
        victim = pcDecodeNext - 32'd4;   // Also the resume point of an interrupt
    irqReq = mStatus[0] && (|(mHwReg & mStatus[15:10]));
    take   = !mStatus[1] && (excValid || irqReq);
    accept = wbCyc && wbStb && !mAck && !take && !eret;
    mTaken = take;
    mAck   = accept;
    if (accept)
        mDatR = modelRead(wbAdr);        // Old contents, a write lands at this edge
    if (take)
    begin
        mStatus[1]                  = 1'b1;
        mCause[causeBdBit]          = excValid && memAny && memBranchDelay;
        mCause[causeIpLow +: 6]     = mHwReg;
        mCause[causeCodeLow +: 5]   = code;
        mEpc                        = victim;
    end
    else if (eret)
    begin
        mStatus[1] = 1'b0;
    end
    else if (accept && wbWe)
    begin
        if (wbAdr == regStatus)
            mStatus = wbDatW;
        else if (wbAdr == regCause)
            mCause = wbDatW;
        else if (wbAdr == regEpc)
            mEpc = wbDatW;
    end
    mHwReg = hwInt;
endtask

`endif

// ==== test/cp0Tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0Tb import cp0Pkg::*;
();

    localparam logic [31:0] statusInit = 32'h0000_FF11;
    localparam logic [31:0] pridValue  = 32'h0001_8000;
    localparam int randomCycles   = 3000;
    localparam int directedCycles = 80;  // Reset plus ten short transfers
    localparam int drainCycles    = 40;
    localparam int cycleLimit     = 4 * (randomCycles + directedCycles + drainCycles);

    logic        clk;
    logic        reset;
    logic        decSyscall;
    logic        decBreak;
    logic        decRi;
    logic [31:0] pcDecodeNext;
    logic        memOv;
    logic        memAdEL;
    logic        memAdES;
    logic        memBranchDelay;
    logic [31:0] pcMemNext;
    logic [5:0]  hwInt;
    logic        eret;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [4:0]  wbAdr;
    logic [31:0] wbDatW;
    logic [31:0] wbDatR;
    logic        wbAck;
    logic        excTaken;
    logic [31:0] handlerPc;
    logic [31:0] epc;
    logic        exl;
    logic        busy;        // Master has a transfer open
    logic [31:0] ackData;
    int          errors;
    int          checks;
    int          cycleCount;
    string       testName;

    `include "cp0Model.svh"

    cp0Top #(
        .STATUS_INIT (statusInit),
        .PRID_VALUE  (pridValue)
    ) u_dut (
        .clk (clk), .reset (reset), .decSyscall (decSyscall), .decBreak (decBreak),
        .decRi (decRi), .pcDecodeNext (pcDecodeNext), .memOv (memOv),
        .memAdEL (memAdEL), .memAdES (memAdES), .memBranchDelay (memBranchDelay),
        .pcMemNext (pcMemNext), .hwInt (hwInt), .eret (eret), .wbCyc (wbCyc),
        .wbStb (wbStb), .wbWe (wbWe), .wbAdr (wbAdr), .wbDatW (wbDatW),
        .wbDatR (wbDatR), .wbAck (wbAck), .excTaken (excTaken),
        .handlerPc (handlerPc), .epc (epc), .exl (exl)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount > cycleLimit)
        begin
            $display("Run stopped at the cycle limit of %0d", cycleLimit);
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic checkOutputs();
        checks++;
        if (excTaken !== mTaken)
        begin
            errors++;
            $display("mismatch %s excTaken expected %0b actual %0b", testName, mTaken, excTaken);
        end
        if (wbAck !== mAck)
        begin
            errors++;
            $display("mismatch %s wbAck expected %0b actual %0b", testName, mAck, wbAck);
        end
        if (mAck && wbDatR !== mDatR)
        begin
            errors++;
            $display("mismatch %s wbDatR expected %h actual %h", testName, mDatR, wbDatR);
        end
        if (exl !== mStatus[1])
        begin
            errors++;
            $display("mismatch %s exl expected %0b actual %0b", testName, mStatus[1], exl);
        end
        if (epc !== mEpc)
        begin
            errors++;
            $display("mismatch %s epc expected %h actual %h", testName, mEpc, epc);
        end
        if (mTaken && handlerPc !== handlerVector)
        begin
            errors++;
            $display("mismatch %s handlerPc expected %h actual %h", testName, handlerVector,
                handlerPc);
        end
    endtask

    // Model and DUT see the same edge, results are checked 1 ns after it
    task automatic stepCycle();
        modelStep();
        @(posedge clk);
        #1;
        checkOutputs();
        if (wbAck)
        begin
            if (!busy)
            begin
                errors++;
                $display("%s: ack arrived with no transfer open", testName);
            end
            ackData = wbDatR;
            busy    = 1'b0;
            wbCyc   = 1'b0;
            wbStb   = 1'b0;
            wbWe    = 1'b0;
        end
    endtask

    task automatic startTransfer(input logic we, input logic [4:0] adr, input logic [31:0] data);
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = adr;
        wbDatW = data;
        busy   = 1'b1;
    endtask

    task automatic busTransfer(input logic we, input logic [4:0] adr, input logic [31:0] data);
        int waited;
        startTransfer(we, adr, data);
        waited = 0;
        while (busy && waited < 20)
        begin
            stepCycle();
            waited++;
        end
        if (busy)
        begin
            errors++;
            $display("%s: no ack for the transfer to address %0d", testName, adr);
        end
        stepCycle();  // Idle cycle between transfers
    endtask

    task automatic readCheck(input logic [4:0] adr, input logic [31:0] expected);
        busTransfer(1'b0, adr, 32'd0);
        checks++;
        if (ackData !== expected)
        begin
            errors++;
            $display("mismatch %s address %0d expected %h actual %h", testName, adr, expected,
                ackData);
        end
    endtask

    initial
    begin
        int addrErr;
        int drained;
        void'($urandom(22677));
        clk = 1'b0;
        reset = 1'b1;
        {decSyscall, decBreak, decRi, memOv, memAdEL, memAdES, memBranchDelay} = '0;
        pcDecodeNext = 32'd0;
        pcMemNext = 32'd0;
        hwInt = 6'd0;
        eret = 1'b0;
        {wbCyc, wbStb, wbWe} = '0;
        wbAdr = 5'd0;
        wbDatW = 32'd0;
        busy = 1'b0;
        ackData = 32'd0;
        errors = 0;
        checks = 0;
        cycleCount = 0;
        testName = "reset";
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        modelReset();

        testName = "reset reads";
        readCheck(regStatus, statusInit);
        readCheck(regCause, 32'd0);
        readCheck(regEpc, 32'd0);
        readCheck(regPrid, pridValue);
        readCheck(5'd0, 32'd0);
        readCheck(5'd31, 32'd0);

        testName = "register writes";
        busTransfer(1'b1, regStatus, 32'hA5A5_FC01);  // EXL clear, IE set
        readCheck(regStatus, 32'hA5A5_FC01);
        busTransfer(1'b1, regPrid, 32'hDEAD_BEEF);
        readCheck(regPrid, pridValue);

        testName = "random traffic";
        for (int i = 0; i < randomCycles; i++)
        begin
            decSyscall = ($urandom_range(0, 15) == 0);
            decBreak = ($urandom_range(0, 15) == 0);
            decRi = ($urandom_range(0, 15) == 0);
            pcDecodeNext = $urandom & 32'hFFFF_FFFC;
            addrErr = $urandom_range(0, 31);  // Never load and store fault together
            memAdEL = (addrErr == 0);
            memAdES = (addrErr == 1);
            memOv = ($urandom_range(0, 15) == 0);
            memBranchDelay = ($urandom_range(0, 1) == 1);
            pcMemNext = $urandom & 32'hFFFF_FFFC;
            if ($urandom_range(0, 7) == 0)
                hwInt = 6'($urandom_range(0, 63));
            eret = ($urandom_range(0, 5) == 0);
            if (!busy && !wbAck && $urandom_range(0, 3) == 0)
                startTransfer($urandom_range(0, 1) == 1, 5'($urandom_range(10, 17)), $urandom);
            stepCycle();
        end

        // Let an open transfer finish on a quiet pipeline
        {decSyscall, decBreak, decRi, memOv, memAdEL, memAdES, eret} = '0;
        drained = 0;
        while (busy && drained < drainCycles)
        begin
            stepCycle();
            drained++;
        end
        if (busy)
        begin
            errors++;
            $display("%s: last transfer never acknowledged", testName);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/cp0Top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0Top
#(
    parameter logic [31:0] STATUS_INIT = 32'h0000_FF11,
    parameter logic [31:0] PRID_VALUE  = 32'h0001_8000
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic        decSyscall,
    input  logic        decBreak,
    input  logic        decRi,
    input  logic [31:0] pcDecodeNext,
    input  logic        memOv,
    input  logic        memAdEL,
    input  logic        memAdES,
    input  logic        memBranchDelay,
    input  logic [31:0] pcMemNext,
    input  logic [5:0]  hwInt,
    input  logic        eret,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic [4:0]  wbAdr,
    input  logic [31:0] wbDatW,
    output logic [31:0] wbDatR,
    output logic        wbAck,
    output logic        excTaken,
    output logic [31:0] handlerPc,
    output logic [31:0] epc,
    output logic        exl
);

    excLink excBus();
    irqLink irqBus();

    excCollector u_excCollector (
        .decSyscall     (decSyscall),
        .decBreak       (decBreak),
        .decRi          (decRi),
        .pcDecodeNext   (pcDecodeNext),
        .memOv          (memOv),
        .memAdEL        (memAdEL),
        .memAdES        (memAdES),
        .memBranchDelay (memBranchDelay),
        .pcMemNext      (pcMemNext),
        .exc            (excBus.source)
    );

    irqSampler u_irqSampler (
        .clk   (clk),
        .reset (reset),
        .hwInt (hwInt),
        .irq   (irqBus.sampler)
    );

    cp0Regs #(
        .STATUS_INIT (STATUS_INIT),
        .PRID_VALUE  (PRID_VALUE)
    ) u_cp0Regs (
        .clk       (clk),
        .reset     (reset),
        .eret      (eret),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .excTaken  (excTaken),
        .handlerPc (handlerPc),
        .epc       (epc),
        .exl       (exl),
        .exc       (excBus.sink),
        .irq       (irqBus.ctrl)
    );

endmodule

`default_nettype wire

// ==== source/cp0Regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0Regs import cp0Pkg::*;
#(
    parameter logic [31:0] STATUS_INIT = 32'h0000_FF11,
    parameter logic [31:0] PRID_VALUE  = 32'h0001_8000
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic        eret,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic [4:0]  wbAdr,
    input  logic [31:0] wbDatW,
    output logic [31:0] wbDatR,
    output logic        wbAck,
    output logic        excTaken,
    output logic [31:0] handlerPc,
    output logic [31:0] epc,
    output logic        exl,
    excLink.sink        exc,
    irqLink.ctrl        irq
);

    statusWord   status;
    logic [31:0] cause;
    logic [31:0] epcReg;
    logic        take;
    logic        busReq;
    logic        accept;
    logic [31:0] readData;

    // Exception beats interrupt, both wait while EXL is set
    assign take = !status.fields.exl && (exc.valid || irq.request);

    // No new request during the ack cycle, the master still holds stb
    assign busReq = wbCyc && wbStb && !wbAck;
    assign accept = busReq && !take && !eret; // Take and ERET hold off the bus

    always_comb
    begin
        case (wbAdr)
            regStatus: readData = status.raw;
            regCause:  readData = cause;
            regEpc:    readData = epcReg;
            regPrid:   readData = PRID_VALUE;
            default:   readData = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            status.raw <= STATUS_INIT;
            cause      <= '0;
            epcReg     <= '0;
        end
        else if (take)
        begin
            status.fields.exl        <= 1'b1;
            cause[causeBdBit]        <= exc.valid & exc.branchDelay;
            cause[causeIpLow +: 6]   <= irq.pending;
            cause[causeCodeLow +: 5] <= exc.valid ? exc.code : excInt;
            epcReg                   <= exc.victimPc; // Decode PC-4 for an interrupt
        end
        else if (eret)
        begin
            status.fields.exl <= 1'b0;
        end
        else if (accept && wbWe)
        begin
            case (wbAdr)
                regStatus: status.raw <= wbDatW;
                regCause:  cause      <= wbDatW;
                regEpc:    epcReg     <= wbDatW;
                default:   ;                      // PRId and unmapped are dropped
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            excTaken <= 1'b0;
            wbAck    <= 1'b0;
        end
        else
        begin
            excTaken <= take;
            wbAck    <= accept;
        end
    end

    // Read data lines up with the ack
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            wbDatR <= readData;
        end
    end

    assign handlerPc  = handlerVector;
    assign epc        = epcReg;
    assign exl        = status.fields.exl;
    assign irq.status = status;

    assert property (@(posedge clk) disable iff (reset) wbAck |=> !wbAck)
        else $error("cp0Regs: wbAck high on two cycles in a row");

    // Pulse lags the take edge, so look at EXL one cycle back
    assert property (@(posedge clk) disable iff (reset) excTaken |-> !$past(exl))
        else $error("cp0Regs: take while EXL was set");

endmodule

`default_nettype wire

// ==== source/irqSampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module irqSampler
(
    input  logic       clk,
    input  logic       reset,
    input  logic [5:0] hwInt,
    irqLink.sampler    irq
);

    logic [5:0] hwIntReg;
    logic [5:0] enabled;

    // Lines are asynchronous to the core, take one sample per cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hwIntReg <= '0;
        end
        else
        begin
            hwIntReg <= hwInt;
        end
    end

    assign enabled = hwIntReg & irq.status.fields.im[7:2]; // IM7..IM2

    assign irq.pending = hwIntReg;
    assign irq.request = irq.status.fields.ie && (|enabled);

endmodule

`default_nettype wire

// ==== source/excCollector.sv ====
`timescale 1ns/1ps
`default_nettype none

module excCollector import cp0Pkg::*;
(
    input  logic        decSyscall,
    input  logic        decBreak,
    input  logic        decRi,
    input  logic [31:0] pcDecodeNext,   // Decode stage PC+4
    input  logic        memOv,
    input  logic        memAdEL,
    input  logic        memAdES,
    input  logic        memBranchDelay,
    input  logic [31:0] pcMemNext,      // Memory stage PC+4
    excLink.source      exc
);

    logic memAny;
    logic decAny;

    assign memAny = memAdEL | memAdES | memOv;
    assign decAny = decRi | decSyscall | decBreak;

    assign exc.valid = memAny | decAny;

    // Memory stage holds the older instruction, so it goes first
    always_comb
    begin
        if (memAdEL)
            exc.code = excAdEL;
        else if (memAdES)
            exc.code = excAdES;
        else if (memOv)
            exc.code = excOv;
        else if (decRi)
            exc.code = excRi;
        else if (decSyscall)
            exc.code = excSyscall;
        else if (decBreak)
            exc.code = excBreak;
        else
            exc.code = excInt;
    end

    // Victim PC back from the PC+4 of the reporting stage
    always_comb
    begin
        if (memAny)
        begin
            if (memBranchDelay)
                exc.victimPc = pcMemNext - 32'd8; // Point at the branch itself
            else
                exc.victimPc = pcMemNext - 32'd4;
        end
        else
        begin
            exc.victimPc = pcDecodeNext - 32'd4;  // Interrupts resume here too
        end
    end

    assign exc.branchDelay = memAny & memBranchDelay;

    // One memory access cannot fault as load and store at once
    always_comb
    begin
        assert #0 (!(memAdEL && memAdES))
            else $error("excCollector: memAdEL and memAdES both high");
    end

endmodule

`default_nettype wire

// ==== source/cp0Links.sv ====
`timescale 1ns/1ps
`default_nettype none

// Chosen synchronous exception, from the collector to the register unit
interface excLink;
    logic        valid;
    logic [4:0]  code;
    logic        branchDelay;
    logic [31:0] victimPc;    // Also carries the decode PC when nothing is valid

    modport source (output valid, output code, output branchDelay, output victimPc);
    modport sink (input valid, input code, input branchDelay, input victimPc);
endinterface

// Status going out to the sampler, interrupt state coming back
interface irqLink import cp0Pkg::*;
();
    statusWord  status;
    logic [5:0] pending;
    logic       request;      // Masked and enabled, EXL not applied

    modport ctrl (output status, input pending, input request);
    modport sampler (input status, output pending, output request);
endinterface

`default_nettype wire

// ==== source/cp0Pkg.sv ====
`default_nettype none

package cp0Pkg;

    // CP0 register numbers, also the Wishbone word address
    localparam logic [4:0] regStatus = 5'd12;
    localparam logic [4:0] regCause  = 5'd13;
    localparam logic [4:0] regEpc    = 5'd14;
    localparam logic [4:0] regPrid   = 5'd15;

    // Exception codes written into Cause
    localparam logic [4:0] excInt     = 5'd0;
    localparam logic [4:0] excAdEL    = 5'd4;  // Load or fetch address error
    localparam logic [4:0] excAdES    = 5'd5;  // Store address error
    localparam logic [4:0] excSyscall = 5'd8;
    localparam logic [4:0] excBreak   = 5'd9;
    localparam logic [4:0] excRi      = 5'd10; // Reserved instruction
    localparam logic [4:0] excOv      = 5'd12; // Arithmetic overflow

    // Status word as seen field by field
    typedef struct packed {
        logic [15:0] upper;
        logic [7:0]  im;       // Upper six bits mask the hardware lines
        logic [5:0]  reserved;
        logic        exl;      // Exception level
        logic        ie;       // Global interrupt enable
    } statusFields;

    // Written by the host as one word, decoded by the take logic as fields
    typedef union packed {
        logic [31:0] raw;
        statusFields fields;
    } statusWord;

    // Cause word layout
    localparam int causeBdBit   = 31;
    localparam int causeIpLow   = 10; // Six hardware pending bits from here up
    localparam int causeCodeLow = 2;  // Five code bits from here up

    // Single handler entry point
    localparam logic [31:0] handlerVector = 32'h8000_0180;

endpackage

`default_nettype wire
